// File: stq_pkg.sv
package stq_pkg;

    localparam int ROB_ID_W     = 6;
    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 64;
    localparam int STQ_ID_W_MAX = 4; // up to 16 entries.

    typedef logic [ROB_ID_W-1:0]     rob_id_t;
    typedef logic [STQ_ID_W_MAX-1:0] stq_id_t;

    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } op_size_e;

    typedef enum logic [1:0] {
        STQ_FREE      = 2'd0,
        STQ_WAIT_DATA = 2'd1, // allocated, address and data pending.
        STQ_READY     = 2'd2,
        STQ_IN_PIPE   = 2'd3
    } stq_state_e;

    typedef enum logic {
        ACT_COMPLETE = 1'b0,
        ACT_REPLAY   = 1'b1
    } pipe_action_e;

    // true when id is younger than or equal to base_id.
    // both are measured as distance from the oldest rob id, so wraparound is handled.
    function automatic logic rob_younger(
        input rob_id_t id,
        input rob_id_t base_id,
        input rob_id_t oldest
    );
        rob_id_t dist_id;
        rob_id_t dist_base;
        dist_id   = rob_id_t'(id - oldest);
        dist_base = rob_id_t'(base_id - oldest);
        return dist_id >= dist_base;
    endfunction

endpackage

// File: stq_config.sv
`timescale 1ns/1ps

module stq_config #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_wr,
    input  logic [3:0] cfg_margin,
    input  logic [4:0] count,
    output logic       stall
);

    logic [3:0] margin_q;
    logic [4:0] threshold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            margin_q <= 4'd2;
        end else if (cfg_wr) begin
            margin_q <= cfg_margin;
        end
    end

    // entries minus margin, held at zero.
    always_comb begin
        if ({1'b0, margin_q} >= 5'(STQ_ENTRIES)) begin
            threshold = '0;
        end else begin
            threshold = 5'(STQ_ENTRIES) - {1'b0, margin_q};
        end
    end

    assign stall = (count >= threshold);

endmodule

// File: stq_age_matrix.sv
`timescale 1ns/1ps

module stq_age_matrix #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [STQ_ENTRIES-1:0] alloc,
    input  logic [STQ_ENTRIES-1:0] valid,
    output logic [STQ_ENTRIES-1:0] elders [STQ_ENTRIES]
);

    logic [STQ_ENTRIES-1:0] rows_q [STQ_ENTRIES];

    // row i holds the entries that were live when i was allocated.
    for (genvar i = 0; i < STQ_ENTRIES; i++) begin : g_row
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rows_q[i] <= '0;
            end else if (alloc[i]) begin
                rows_q[i] <= valid;
            end else begin
                rows_q[i] <= rows_q[i] & valid; // drop freed elders.
            end
        end

        // mask covers the cycle between a free and the row update.
        assign elders[i] = rows_q[i] & valid;
    end

endmodule

// File: stq_pipe_arb.sv
`timescale 1ns/1ps

module stq_pipe_arb #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic [STQ_ENTRIES-1:0]        reqs,
    input  logic [STQ_ENTRIES-1:0]        elders [STQ_ENTRIES],
    input  logic [stq_pkg::ADDR_W-1:0]    addrs [STQ_ENTRIES],
    input  logic [stq_pkg::DATA_W-1:0]    datas [STQ_ENTRIES],
    input  stq_pkg::op_size_e             sizes [STQ_ENTRIES],
    output logic                          pipe_req,
    output stq_pkg::stq_id_t              pipe_stqid,
    output logic [stq_pkg::ADDR_W-1:0]    pipe_addr,
    output logic [stq_pkg::DATA_W-1:0]    pipe_data,
    output stq_pkg::op_size_e             pipe_size,
    input  logic                          gnt_in,
    output logic [STQ_ENTRIES-1:0]        gnts
);

    logic [STQ_ENTRIES-1:0] sel;

    // winner has no elder that is also requesting.
    for (genvar i = 0; i < STQ_ENTRIES; i++) begin : g_sel
        assign sel[i] = reqs[i] & ~|(reqs & elders[i]);
    end

    always_comb begin
        pipe_stqid = '0;
        pipe_addr  = '0;
        pipe_data  = '0;
        pipe_size  = stq_pkg::SIZE_BYTE;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (sel[i]) begin
                pipe_stqid = stq_pkg::stq_id_t'(i);
                pipe_addr  = addrs[i];
                pipe_data  = datas[i];
                pipe_size  = sizes[i];
            end
        end
    end

    assign pipe_req = |sel;
    assign gnts     = sel & {STQ_ENTRIES{gnt_in}};

endmodule

// File: stq_entry.sv
`timescale 1ns/1ps

module stq_entry #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  stq_pkg::stq_id_t           id,
    input  logic                       alloc,
    input  stq_pkg::rob_id_t           alloc_robid,
    input  stq_pkg::op_size_e          alloc_size,
    input  logic                       iss_hit,
    input  logic [stq_pkg::ADDR_W-1:0] iss_addr,
    input  logic [stq_pkg::DATA_W-1:0] iss_data,
    input  stq_pkg::rob_id_t           oldest_robid,
    input  logic                       nuke_valid,
    input  stq_pkg::rob_id_t           nuke_robid,
    input  logic                       gnt,
    input  logic                       done_valid,
    input  stq_pkg::stq_id_t           done_stqid,
    input  stq_pkg::pipe_action_e      done_action,
    output logic                       valid,
    output logic                       req,
    output logic [stq_pkg::ADDR_W-1:0] addr,
    output logic [stq_pkg::DATA_W-1:0] data,
    output stq_pkg::op_size_e          size
);

    stq_pkg::stq_state_e state_q;
    stq_pkg::stq_state_e state_d;
    stq_pkg::rob_id_t    robid_q;
    logic                squash;
    logic                done_hit;

    assign done_hit = done_valid && (done_stqid == id) && (id < STQ_ENTRIES);

    // a grant in the nuke cycle keeps the entry, the pipe already has it.
    assign squash = nuke_valid
                 && (state_q == stq_pkg::STQ_WAIT_DATA || state_q == stq_pkg::STQ_READY)
                 && !gnt
                 && stq_pkg::rob_younger(robid_q, nuke_robid, oldest_robid);

    always_comb begin
        state_d = state_q;
        if (squash) begin
            state_d = stq_pkg::STQ_FREE;
        end else begin
            case (state_q)
                stq_pkg::STQ_FREE:      if (alloc) state_d = stq_pkg::STQ_WAIT_DATA;
                stq_pkg::STQ_WAIT_DATA: if (iss_hit) state_d = stq_pkg::STQ_READY;
                stq_pkg::STQ_READY:     if (gnt) state_d = stq_pkg::STQ_IN_PIPE;
                stq_pkg::STQ_IN_PIPE: begin
                    if (done_hit) begin
                        state_d = (done_action == stq_pkg::ACT_REPLAY) ?
                                  stq_pkg::STQ_READY : stq_pkg::STQ_FREE;
                    end
                end
                default: state_d = stq_pkg::STQ_FREE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= stq_pkg::STQ_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc && state_q == stq_pkg::STQ_FREE) begin
            robid_q <= alloc_robid;
            size    <= alloc_size;
        end
        if (iss_hit && state_q == stq_pkg::STQ_WAIT_DATA) begin
            addr <= iss_addr;
            data <= iss_data;
        end
    end

    assign valid = (state_q != stq_pkg::STQ_FREE);
    assign req   = (state_q == stq_pkg::STQ_READY) && (robid_q == oldest_robid); // oldest only.

endmodule

// File: storeq.sv
`timescale 1ns/1ps

module storeq #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       disp_valid,
    input  logic                       disp_is_store,
    input  stq_pkg::rob_id_t           disp_robid,
    input  stq_pkg::op_size_e          disp_size,
    output stq_pkg::stq_id_t           stq_id_alloc,
    input  logic                       iss_valid,
    input  stq_pkg::stq_id_t           iss_stqid,
    input  logic [stq_pkg::ADDR_W-1:0] iss_addr,
    input  logic [stq_pkg::DATA_W-1:0] iss_data,
    input  logic                       nuke_valid,
    input  stq_pkg::rob_id_t           nuke_robid,
    input  stq_pkg::rob_id_t           oldest_robid,
    output logic                       pipe_req,
    output stq_pkg::stq_id_t           pipe_stqid,
    output logic [stq_pkg::ADDR_W-1:0] pipe_addr,
    output logic [stq_pkg::DATA_W-1:0] pipe_data,
    output stq_pkg::op_size_e          pipe_size,
    input  logic                       pipe_gnt,
    input  logic                       done_valid,
    input  stq_pkg::stq_id_t           done_stqid,
    input  stq_pkg::pipe_action_e      done_action,
    output logic [4:0]                 count,
    output logic                       idle,
    output logic                       full
);

    logic                       q_alloc;
    logic                       iss_ql;
    logic [STQ_ENTRIES-1:0]     alloc_sel;
    logic [STQ_ENTRIES-1:0]     e_alloc;
    logic [STQ_ENTRIES-1:0]     e_valid;
    logic [STQ_ENTRIES-1:0]     e_req;
    logic [STQ_ENTRIES-1:0]     e_gnt;
    logic [STQ_ENTRIES-1:0]     e_elders [STQ_ENTRIES];
    logic [stq_pkg::ADDR_W-1:0] e_addr [STQ_ENTRIES];
    logic [stq_pkg::DATA_W-1:0] e_data [STQ_ENTRIES];
    stq_pkg::op_size_e          e_size [STQ_ENTRIES];

    assign q_alloc = disp_valid & disp_is_store & ~nuke_valid;
    assign iss_ql  = iss_valid & ~nuke_valid; // issue in a nuke cycle is lost.

    // lowest free slot.
    always_comb begin
        logic found;
        found        = 1'b0;
        alloc_sel    = '0;
        stq_id_alloc = '0;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (!e_valid[i] && !found) begin
                found        = 1'b1;
                alloc_sel[i] = 1'b1;
                stq_id_alloc = stq_pkg::stq_id_t'(i);
            end
        end
    end

    assign e_alloc = q_alloc ? alloc_sel : '0;

    for (genvar e = 0; e < STQ_ENTRIES; e++) begin : g_entries
        stq_entry #(.STQ_ENTRIES(STQ_ENTRIES)) stq_entry_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .id           (stq_pkg::stq_id_t'(e)),
            .alloc        (e_alloc[e]),
            .alloc_robid  (disp_robid),
            .alloc_size   (disp_size),
            .iss_hit      (iss_ql && (iss_stqid == stq_pkg::stq_id_t'(e))),
            .iss_addr     (iss_addr),
            .iss_data     (iss_data),
            .oldest_robid (oldest_robid),
            .nuke_valid   (nuke_valid),
            .nuke_robid   (nuke_robid),
            .gnt          (e_gnt[e]),
            .done_valid   (done_valid),
            .done_stqid   (done_stqid),
            .done_action  (done_action),
            .valid        (e_valid[e]),
            .req          (e_req[e]),
            .addr         (e_addr[e]),
            .data         (e_data[e]),
            .size         (e_size[e])
        );
    end

    stq_age_matrix #(.STQ_ENTRIES(STQ_ENTRIES)) age_mtx_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .alloc  (e_alloc),
        .valid  (e_valid),
        .elders (e_elders)
    );

    stq_pipe_arb #(.STQ_ENTRIES(STQ_ENTRIES)) pipe_arb_i (
        .reqs       (e_req),
        .elders     (e_elders),
        .addrs      (e_addr),
        .datas      (e_data),
        .sizes      (e_size),
        .pipe_req   (pipe_req),
        .pipe_stqid (pipe_stqid),
        .pipe_addr  (pipe_addr),
        .pipe_data  (pipe_data),
        .pipe_size  (pipe_size),
        .gnt_in     (pipe_gnt),
        .gnts       (e_gnt)
    );

    always_comb begin
        count = '0;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (e_valid[i]) count = count + 5'd1;
        end
    end

    assign idle = ~|e_valid;
    assign full = &e_valid;

endmodule

// File: stq_top.sv
`timescale 1ns/1ps

module stq_top #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       disp_valid,
    input  logic                       disp_is_store,
    input  stq_pkg::rob_id_t           disp_robid,
    input  stq_pkg::op_size_e          disp_size,
    output stq_pkg::stq_id_t           stq_id_alloc,
    input  logic                       iss_valid,
    input  stq_pkg::stq_id_t           iss_stqid,
    input  logic [stq_pkg::ADDR_W-1:0] iss_addr,
    input  logic [stq_pkg::DATA_W-1:0] iss_data,
    input  logic                       nuke_valid,
    input  stq_pkg::rob_id_t           nuke_robid,
    input  stq_pkg::rob_id_t           oldest_robid,
    output logic                       pipe_req,
    output stq_pkg::stq_id_t           pipe_stqid,
    output logic [stq_pkg::ADDR_W-1:0] pipe_addr,
    output logic [stq_pkg::DATA_W-1:0] pipe_data,
    output stq_pkg::op_size_e          pipe_size,
    input  logic                       pipe_gnt,
    input  logic                       done_valid,
    input  stq_pkg::stq_id_t           done_stqid,
    input  stq_pkg::pipe_action_e      done_action,
    input  logic                       cfg_wr,
    input  logic [3:0]                 cfg_margin,
    output logic                       idle,
    output logic                       full,
    output logic                       stall
);

    logic [4:0] count; // live entries, feeds the stall compare.

    storeq #(.STQ_ENTRIES(STQ_ENTRIES)) storeq_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_is_store (disp_is_store),
        .disp_robid    (disp_robid),
        .disp_size     (disp_size),
        .stq_id_alloc  (stq_id_alloc),
        .iss_valid     (iss_valid),
        .iss_stqid     (iss_stqid),
        .iss_addr      (iss_addr),
        .iss_data      (iss_data),
        .nuke_valid    (nuke_valid),
        .nuke_robid    (nuke_robid),
        .oldest_robid  (oldest_robid),
        .pipe_req      (pipe_req),
        .pipe_stqid    (pipe_stqid),
        .pipe_addr     (pipe_addr),
        .pipe_data     (pipe_data),
        .pipe_size     (pipe_size),
        .pipe_gnt      (pipe_gnt),
        .done_valid    (done_valid),
        .done_stqid    (done_stqid),
        .done_action   (done_action),
        .count         (count),
        .idle          (idle),
        .full          (full)
    );

    stq_config #(.STQ_ENTRIES(STQ_ENTRIES)) stq_config_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_margin (cfg_margin),
        .count      (count),
        .stall      (stall)
    );

endmodule

// File: tb_stq_asserts.sv
`timescale 1ns/1ps

module tb_stq_asserts #(
    parameter int STQ_ENTRIES = 8
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   disp_valid,
    input logic                   disp_is_store,
    input logic                   nuke_valid,
    input stq_pkg::rob_id_t       oldest_robid,
    input logic                   pipe_req,
    input stq_pkg::stq_id_t       pipe_stqid,
    input logic                   pipe_gnt,
    input logic [STQ_ENTRIES-1:0] gnts,
    input logic                   idle,
    input logic                   full
);

    a_no_disp_full: assert property (@(posedge clk) disable iff (!rst_n)
        disp_valid && disp_is_store |-> !full)
        else $error("dispatch into a full queue");

    // back-pressure, the request waits unchanged.
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_req && !pipe_gnt |=> (pipe_req && $stable(pipe_stqid))
                                  || $changed(oldest_robid) || $past(nuke_valid))
        else $error("request dropped or changed before grant");

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnts))
        else $error("grant is not one-hot");

    // a taken store leaves the queue busy.
    a_disp_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        disp_valid && disp_is_store && !nuke_valid |=> !idle)
        else $error("queue idle after a store dispatch");

endmodule

bind storeq tb_stq_asserts #(.STQ_ENTRIES(STQ_ENTRIES)) asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .disp_valid    (disp_valid),
    .disp_is_store (disp_is_store),
    .nuke_valid    (nuke_valid),
    .oldest_robid  (oldest_robid),
    .pipe_req      (pipe_req),
    .pipe_stqid    (pipe_stqid),
    .pipe_gnt      (pipe_gnt),
    .gnts          (e_gnt),
    .idle          (idle),
    .full          (full)
);

// File: tb_stq.sv
`timescale 1ns/1ps

module tb_stq;

    localparam int STQ_ENTRIES = 8;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_SEQ     = 4096;

    typedef struct packed {
        logic [stq_pkg::ADDR_W-1:0] addr;
        logic [stq_pkg::DATA_W-1:0] data;
        stq_pkg::op_size_e          size;
    } store_t;

    logic                       clk;
    logic                       rst_n;
    logic                       disp_valid;
    logic                       disp_is_store;
    stq_pkg::rob_id_t           disp_robid;
    stq_pkg::op_size_e          disp_size;
    stq_pkg::stq_id_t           stq_id_alloc;
    logic                       iss_valid;
    stq_pkg::stq_id_t           iss_stqid;
    logic [stq_pkg::ADDR_W-1:0] iss_addr;
    logic [stq_pkg::DATA_W-1:0] iss_data;
    logic                       nuke_valid;
    stq_pkg::rob_id_t           nuke_robid;
    stq_pkg::rob_id_t           oldest_robid;
    logic                       pipe_req;
    stq_pkg::stq_id_t           pipe_stqid;
    logic [stq_pkg::ADDR_W-1:0] pipe_addr;
    logic [stq_pkg::DATA_W-1:0] pipe_data;
    stq_pkg::op_size_e          pipe_size;
    logic                       pipe_gnt;
    logic                       done_valid;
    stq_pkg::stq_id_t           done_stqid;
    stq_pkg::pipe_action_e      done_action;
    logic                       cfg_wr;
    logic [3:0]                 cfg_margin;
    logic                       idle;
    logic                       full;
    logic                       stall;

    // rob and memory pipe model.
    int               cyc;
    int               seq_q[$]; // live stores, oldest first.
    stq_pkg::stq_id_t seq_id [MAX_SEQ];
    stq_pkg::rob_id_t seq_rob [MAX_SEQ];
    bit               seq_iss [MAX_SEQ];
    bit               used [STQ_ENTRIES];
    int               next_seq;
    stq_pkg::rob_id_t next_rob;
    int               margin_m;
    bit               inflight;
    int               done_cyc;
    int               replay_pct;
    int               pend_cfg;
    int               pend_nuke;
    int               exp_count;
    int               exp_id;
    bit               exp_stall;
    int               err_cnt;
    int               chk_cnt;
    int               test_base;
    string            test_name;

    stq_top #(.STQ_ENTRIES(STQ_ENTRIES)) stq_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("Regression failed");
        $finish;
    end

    // expected store stream, one store per dispatch sequence number.
    function automatic store_t ref_store(input int seq);
        store_t s;
        s.addr = 32'h4000_0000 + 32'(seq) * 32'd8;
        s.data = {32'(seq) ^ 32'h5a5a_0000, ~32'(seq)};
        s.size = stq_pkg::op_size_e'(2'(seq));
        return s;
    endfunction

    function automatic int lowest_free();
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (!used[i]) return i;
        end
        return -1;
    endfunction

    function automatic int used_count();
        int n;
        n = 0;
        for (int i = 0; i < STQ_ENTRIES; i++) n += used[i];
        return n;
    endfunction

    task automatic check_flag(input string what, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s %s: expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic check_id(input string what, input stq_pkg::stq_id_t exp,
                            input stq_pkg::stq_id_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_store(input store_t exp, input store_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s store: expected %h/%h/%0d actual %h/%h/%0d", test_name,
                     exp.addr, exp.data, exp.size, act.addr, act.data, act.size);
        end
    endtask

    task automatic fail_msg(input string what);
        err_cnt++;
        $display("%s: %s", test_name, what);
    endtask

    // one clock of stimulus; the snapshot is what the dut holds in this cycle.
    task automatic tick(input int disp_pct, input int iss_pct);
        int     cand[$];
        int     h;
        int     k;
        store_t s;
        @(posedge clk);
        cyc++;
        exp_count = used_count();
        exp_id    = lowest_free();
        exp_stall = exp_count >= ((margin_m >= STQ_ENTRIES) ? 0 : STQ_ENTRIES - margin_m);
        disp_valid <= 1'b0;
        iss_valid  <= 1'b0;
        nuke_valid <= 1'b0;
        cfg_wr     <= 1'b0;
        done_valid <= 1'b0;
        pipe_gnt   <= ($urandom % 100) < 70;
        if (pend_cfg >= 0) begin
            cfg_wr     <= 1'b1;
            cfg_margin <= 4'(pend_cfg);
            margin_m = pend_cfg;
            pend_cfg = -1;
        end
        if (pend_nuke > 0) begin
            pipe_gnt   <= 1'b0; // keeps the squash free of grant races.
            nuke_valid <= 1'b1;
            nuke_robid <= seq_rob[seq_q[pend_nuke]];
            next_rob = seq_rob[seq_q[pend_nuke]];
            while (seq_q.size() > pend_nuke) begin
                h = seq_q.pop_back();
                used[seq_id[h]] = 1'b0;
            end
            pend_nuke = 0;
        end else begin
            foreach (seq_q[i]) if (!seq_iss[seq_q[i]]) cand.push_back(seq_q[i]);
            if (cand.size() > 0 && ($urandom % 100) < iss_pct) begin
                h = cand[$urandom % cand.size()];
                s = ref_store(h);
                iss_valid <= 1'b1;
                iss_stqid <= seq_id[h];
                iss_addr  <= s.addr;
                iss_data  <= s.data;
                seq_iss[h] = 1'b1;
            end
            if (exp_count < STQ_ENTRIES - margin_m && ($urandom % 100) < disp_pct) begin
                k = lowest_free();
                s = ref_store(next_seq);
                seq_id[next_seq]  = stq_pkg::stq_id_t'(k);
                seq_rob[next_seq] = next_rob;
                seq_iss[next_seq] = 1'b0;
                seq_q.push_back(next_seq);
                used[k] = 1'b1;
                disp_valid    <= 1'b1;
                disp_is_store <= 1'b1;
                disp_robid    <= next_rob;
                disp_size     <= s.size;
                next_seq++;
                next_rob++;
            end
        end
        if (inflight && cyc == done_cyc) begin
            h = seq_q[0];
            inflight = 1'b0;
            done_valid <= 1'b1;
            done_stqid <= seq_id[h];
            if (($urandom % 100) < replay_pct) begin
                done_action <= stq_pkg::ACT_REPLAY;
            end else begin
                done_action <= stq_pkg::ACT_COMPLETE;
                void'(seq_q.pop_front());
                used[seq_id[h]] = 1'b0;
            end
        end
        oldest_robid <= (seq_q.size() > 0) ? seq_rob[seq_q[0]] : next_rob;
    endtask

    // compares the dut against the model in the middle of each cycle.
    always @(negedge clk) begin
        int     h;
        store_t act;
        if (rst_n) begin
            check_flag("idle", exp_count == 0, idle);
            check_flag("full", exp_count == STQ_ENTRIES, full);
            check_flag("stall", exp_stall, stall);
            if (exp_id >= 0) check_id("alloc id", stq_pkg::stq_id_t'(exp_id), stq_id_alloc);
            if (pipe_req && (seq_q.size() == 0 || inflight || !seq_iss[seq_q[0]])) begin
                fail_msg("request raised by a store that is not the oldest ready one");
            end else if (pipe_req && pipe_gnt) begin
                h = seq_q[0];
                act.addr = pipe_addr;
                act.data = pipe_data;
                act.size = pipe_size;
                check_store(ref_store(h), act);
                check_id("pipe id", seq_id[h], pipe_stqid);
                inflight = 1'b1;
                done_cyc = cyc + 6; // five cycles after the grant edge.
            end
        end
    end

    task automatic drain();
        while (seq_q.size() != 0 || inflight) tick(0, 60);
        tick(0, 0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = err_cnt;
    endtask

    task automatic end_test();
        $display("test %-10s %s, %0d errors", test_name,
                 (err_cnt == test_base) ? "ok" : "FAILED", err_cnt - test_base);
    endtask

    initial begin
        void'($urandom(92649));
        rst_n = 1'b0;
        disp_valid = 1'b0;
        disp_is_store = 1'b0;
        disp_robid = '0;
        disp_size = stq_pkg::SIZE_BYTE;
        iss_valid = 1'b0;
        iss_stqid = '0;
        iss_addr = '0;
        iss_data = '0;
        nuke_valid = 1'b0;
        nuke_robid = '0;
        oldest_robid = '0;
        pipe_gnt = 1'b0;
        done_valid = 1'b0;
        done_stqid = '0;
        done_action = stq_pkg::ACT_COMPLETE;
        cfg_wr = 1'b0;
        cfg_margin = 4'd2;
        margin_m = 2;
        next_rob = '0;
        replay_pct = 10;
        pend_cfg = -1;
        pend_nuke = 0;
        exp_id = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset");
        repeat (3) tick(0, 0);
        @(negedge clk);
        check_flag("pipe_req", 1'b0, pipe_req);
        end_test();

        start_test("alloc_ids");
        repeat (4) tick(100, 0); // ids 0..3 in turn.
        drain();
        end_test();

        start_test("stream");
        repeat (400) tick(40, 50);
        drain();
        end_test();

        start_test("replay");
        replay_pct = 60;
        repeat (300) tick(40, 50);
        drain();
        replay_pct = 10;
        end_test();

        start_test("nuke");
        repeat (6) tick(100, 0);
        repeat (2) tick(0, 100);
        pend_nuke = 3;
        tick(0, 0);
        repeat (4) tick(100, 0); // squashed ids come back.
        drain();
        end_test();

        start_test("stall");
        pend_cfg = 3;
        tick(0, 0);
        repeat (8) tick(100, 0);
        pend_cfg = 0;
        repeat (5) tick(100, 0);
        tick(0, 0);
        @(negedge clk);
        check_flag("full at 8", 1'b1, full);
        drain();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
stq_pkg.sv
stq_config.sv
stq_age_matrix.sv
stq_pipe_arb.sv
stq_entry.sv
storeq.sv
stq_top.sv
tb_stq_asserts.sv
tb_stq.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_stq
FILELIST  ?= vlog.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
